//--- common/sv39_pkg.sv
`default_nettype none

package sv39_pkg;

    // Address and entry widths for Sv39
    localparam int unsigned VaWidth  = 39;
    localparam int unsigned PaWidth  = 56;
    localparam int unsigned PpnWidth = 44;
    localparam int unsigned VpnWidth = 27;
    localparam int unsigned PteWidth = 64;

    // Page table entry, MSB first as laid out in memory
    typedef struct packed {
        logic [9:0]          reserved;
        logic [PpnWidth-1:0] ppn;
        logic [1:0]          rsw;
        logic                d;
        logic                a;
        logic                g;
        logic                u;
        logic                x;
        logic                w;
        logic                r;
        logic                v;
    } pte_t;

    // LVL1 is the root table, a leaf here maps 1G
    typedef enum logic [1:0] {
        LVL1 = 2'd0,
        LVL2 = 2'd1,
        LVL3 = 2'd2
    } pt_level_e;

    // VPN[2], VPN[1] or VPN[0] of the IOVA
    function automatic logic [8:0] vpn_slice(input logic [VaWidth-1:0] iova,
                                             input pt_level_e          lvl);
        case (lvl)
            LVL1:    return iova[38:30];
            LVL2:    return iova[29:21];
            default: return iova[20:12];
        endcase
    endfunction

    // Byte address of the PTE for this level, entries are 8 bytes wide
    function automatic logic [PaWidth-1:0] pte_addr(input logic [PpnWidth-1:0] ppn,
                                                    input logic [VaWidth-1:0]  iova,
                                                    input pt_level_e           lvl);
        return {ppn, vpn_slice(iova, lvl), 3'b000};
    endfunction

endpackage

`default_nettype wire

//--- common/ptw_fault_pkg.sv
`default_nettype none

package ptw_fault_pkg;

    // Width of the IOMMU fault cause field
    localparam int unsigned CauseWidth = 12;

    // Page faults, selected by the access type of the request
    localparam logic [CauseWidth-1:0] LOAD_PAGE_FAULT  = 12'd13;
    localparam logic [CauseWidth-1:0] STORE_PAGE_FAULT = 12'd15;

    // Error response while fetching a PTE
    localparam logic [CauseWidth-1:0] PT_DATA_CORRUPTION = 12'd274;

    // How a walk ended
    typedef enum logic [1:0] {
        // Leaf found and all checks passed
        FAULT_NONE = 2'd0,
        // One of the PTE rules was broken
        FAULT_PAGE = 2'd1,
        // Memory returned a non-OKAY response
        FAULT_BUS  = 2'd2
    } fault_e;

endpackage

`default_nettype wire

//--- common/walk_req_if.sv
`default_nettype none
`timescale 1ns/10ps

interface walk_req_if #(
    parameter int unsigned PscidWidth = 20
) ();
    import sv39_pkg::*;

    // One-cycle pulse, fields below are held for the whole walk
    logic                  start;
    logic [VaWidth-1:0]    iova;
    logic [PscidWidth-1:0] pscid;
    logic                  is_store;
    // Root table from iosatp
    logic [PpnWidth-1:0]   root_ppn;

    modport intake (
        output start, iova, pscid, is_store, root_ppn
    );

    modport walker (
        input start, iova, pscid, is_store, root_ppn
    );

endinterface

`default_nettype wire

//--- common/walk_res_if.sv
`default_nettype none
`timescale 1ns/10ps

interface walk_res_if #(
    parameter int unsigned PscidWidth = 20
) ();
    import sv39_pkg::*;
    import ptw_fault_pkg::*;

    // Outcome is only meaningful while done is high
    logic                  done;
    fault_e                fault;
    pt_level_e             level;
    pte_t                  leaf_pte;
    // OR of the g bits along the walk
    logic                  global_map;
    // Request fields carried along for the IOTLB tag
    logic [VpnWidth-1:0]   vpn;
    logic [PscidWidth-1:0] pscid;
    logic                  is_store;

    modport walker (
        output done, fault, level, leaf_pte, global_map, vpn, pscid, is_store
    );

    modport report (
        input done, fault, level, leaf_pte, global_map, vpn, pscid, is_store
    );

endinterface

`default_nettype wire

//--- logic/ptw_req_intake.sv
`default_nettype none
`timescale 1ns/10ps

module ptw_req_intake #(
    parameter int unsigned PscidWidth = 20
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          init_ptw_i,
    input  logic                          busy_i,
    input  logic [sv39_pkg::VaWidth-1:0]  iova_i,
    input  logic [PscidWidth-1:0]         pscid_i,
    input  logic                          is_store_i,
    input  logic [sv39_pkg::PpnWidth-1:0] root_ppn_i,
    walk_req_if.intake                    req
);
    import sv39_pkg::*;

    logic                  trig_q;
    logic                  start_q;
    logic                  accept;
    logic [VaWidth-1:0]    iova_q;
    logic [PscidWidth-1:0] pscid_q;
    logic                  is_store_q;
    logic [PpnWidth-1:0]   root_ppn_q;

    // Rising edge of the trigger is dropped while a walk is running
    assign accept = init_ptw_i && !trig_q && !busy_i;

    // Previous trigger sample is kept even when the edge is ignored
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            trig_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            trig_q  <= init_ptw_i;
            start_q <= accept;
        end
    end

    // Request fields stay put until the next accepted edge
    always_ff @(posedge clk_i) begin
        if (accept) begin
            iova_q     <= iova_i;
            pscid_q    <= pscid_i;
            is_store_q <= is_store_i;
            root_ppn_q <= root_ppn_i;
        end
    end

    assign req.start    = start_q;
    assign req.iova     = iova_q;
    assign req.pscid    = pscid_q;
    assign req.is_store = is_store_q;
    assign req.root_ppn = root_ppn_q;

    // Walker raises busy with the start pulse so a second edge is dropped
    start_sets_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        start_q |-> busy_i);

endmodule

`default_nettype wire

//--- walker/ptw_walker.sv
`default_nettype none
`timescale 1ns/10ps

module ptw_walker (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    walk_req_if.walker                   req,
    walk_res_if.walker                   res,
    output logic                         busy_o,
    output logic                         ar_valid_o,
    output logic [sv39_pkg::PaWidth-1:0] ar_addr_o,
    input  logic                         ar_ready_i,
    input  logic                         r_valid_i,
    input  sv39_pkg::pte_t               r_data_i,
    input  logic [1:0]                   r_resp_i,
    output logic                         r_ready_o
);
    import sv39_pkg::*;
    import ptw_fault_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WAIT
    } walk_state_e;

    localparam logic [1:0] RespOkay = 2'b00;

    walk_state_e        state_q, state_d;
    pt_level_e          lvl_q, lvl_d;
    logic [PaWidth-1:0] pptr_q, pptr_d;
    logic               global_q, global_d;

    logic walk_done;
    logic leaf;
    logic bad_entry;
    logic misaligned;
    logic leaf_fault;
    logic nonleaf_fault;
    logic page_fault;
    logic bus_fault;

    // PTE checks, only looked at while a beat is in the wait state
    // r or x set marks a leaf
    assign leaf = r_data_i.r || r_data_i.x;

    // Invalid, write-only or reserved bits in use
    assign bad_entry = !r_data_i.v || (r_data_i.w && !r_data_i.r) || (|r_data_i.reserved);

    // Superpage PPN must be aligned to its size
    assign misaligned = ((lvl_q == LVL1) && (|r_data_i.ppn[17:0]))
                     || ((lvl_q == LVL2) && (|r_data_i.ppn[8:0]));

    // Leaf needs r and a, and d on a store
    assign leaf_fault = leaf && (!r_data_i.r || !r_data_i.a
                              || (req.is_store && !r_data_i.d) || misaligned);

    // Pointer entries keep a, d, u clear and cannot sit at the last level
    assign nonleaf_fault = !leaf && (r_data_i.a || r_data_i.d || r_data_i.u
                                  || (lvl_q == LVL3));

    assign page_fault = bad_entry || leaf_fault || nonleaf_fault;
    assign bus_fault  = (r_resp_i != RespOkay);

    always_comb begin
        state_d   = state_q;
        lvl_d     = lvl_q;
        pptr_d    = pptr_q;
        global_d  = global_q;
        walk_done = 1'b0;
        r_ready_o = 1'b0;

        case (state_q)
            ST_IDLE: begin
                // New walk begins at the root table
                if (req.start) begin
                    state_d  = ST_ADDR;
                    lvl_d    = LVL1;
                    global_d = 1'b0;
                    pptr_d   = pte_addr(req.root_ppn, req.iova, LVL1);
                end
            end

            ST_ADDR: begin
                // Address held until accepted
                if (ar_ready_i) begin
                    state_d = ST_WAIT;
                end
            end

            ST_WAIT: begin
                if (r_valid_i) begin
                    r_ready_o = 1'b1;
                    global_d  = global_q | r_data_i.g;

                    // Any fault or a clean leaf ends the walk on this beat
                    if (bus_fault || page_fault || leaf) begin
                        walk_done = 1'b1;
                        state_d   = ST_IDLE;
                    end else begin
                        // Descend one level through the pointer entry
                        state_d = ST_ADDR;
                        lvl_d   = (lvl_q == LVL1) ? LVL2 : LVL3;
                        pptr_d  = pte_addr(r_data_i.ppn, req.iova, lvl_d);
                    end
                end
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= ST_IDLE;
            lvl_q    <= LVL1;
            global_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            lvl_q    <= lvl_d;
            global_q <= global_d;
        end
    end

    always_ff @(posedge clk_i) begin
        pptr_q <= pptr_d;
    end

    // Active from the start pulse through the done beat
    assign busy_o     = req.start || (state_q != ST_IDLE);
    assign ar_valid_o = (state_q == ST_ADDR);
    assign ar_addr_o  = pptr_q;

    // Outcome of the ending beat, bus error wins over the PTE checks
    assign res.done       = walk_done;
    assign res.fault      = bus_fault ? FAULT_BUS : (page_fault ? FAULT_PAGE : FAULT_NONE);
    assign res.level      = lvl_q;
    assign res.leaf_pte   = r_data_i;
    assign res.global_map = global_q | r_data_i.g;
    assign res.vpn        = req.iova[VaWidth-1:VaWidth-VpnWidth];
    assign res.pscid      = req.pscid;
    assign res.is_store   = req.is_store;

    // Read request must not change while it is stalled
    ar_addr_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

    // Done only while busy, and the intake cannot restart in the next cycle
    done_ends_walk_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        walk_done |-> busy_o ##1 !busy_o);

endmodule

`default_nettype wire

//--- logic/ptw_outcome_report.sv
`default_nettype none
`timescale 1ns/10ps

module ptw_outcome_report #(
    parameter int unsigned PscidWidth = 20
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    walk_res_if.report                          res,
    output logic                                update_o,
    output logic                                up_1g_o,
    output logic                                up_2m_o,
    output logic [sv39_pkg::VpnWidth-1:0]       up_vpn_o,
    output logic [PscidWidth-1:0]               up_pscid_o,
    output sv39_pkg::pte_t                      up_pte_o,
    output logic                                ptw_error_o,
    output logic [ptw_fault_pkg::CauseWidth-1:0] cause_code_o
);
    import sv39_pkg::*;
    import ptw_fault_pkg::*;

    logic                  update_q;
    logic                  error_q;
    logic                  is_1g_q;
    logic                  is_2m_q;
    logic [VpnWidth-1:0]   vpn_q;
    logic [PscidWidth-1:0] pscid_q;
    pte_t                  pte_q;
    logic [CauseWidth-1:0] cause_q;
    pte_t                  leaf_pte;
    logic [CauseWidth-1:0] cause;

    // Global from any level of the walk goes into the IOTLB entry
    always_comb begin
        leaf_pte   = res.leaf_pte;
        leaf_pte.g = res.leaf_pte.g | res.global_map;
    end

    // Bus errors report data corruption, otherwise by access type
    assign cause = (res.fault == FAULT_BUS) ? PT_DATA_CORRUPTION
                 : (res.is_store ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            update_q <= 1'b0;
            error_q  <= 1'b0;
        end else begin
            update_q <= res.done && (res.fault == FAULT_NONE);
            error_q  <= res.done && (res.fault != FAULT_NONE);
        end
    end

    always_ff @(posedge clk_i) begin
        if (res.done) begin
            is_1g_q <= (res.level == LVL1);
            is_2m_q <= (res.level == LVL2);
            vpn_q   <= res.vpn;
            pscid_q <= res.pscid;
            pte_q   <= leaf_pte;
            cause_q <= cause;
        end
    end

    // Pulses, payload reads as zero outside its pulse
    assign update_o     = update_q;
    assign up_1g_o      = update_q && is_1g_q;
    assign up_2m_o      = update_q && is_2m_q;
    assign up_vpn_o     = update_q ? vpn_q : '0;
    assign up_pscid_o   = update_q ? pscid_q : '0;
    assign up_pte_o     = update_q ? pte_q : '0;
    assign ptw_error_o  = error_q;
    assign cause_code_o = error_q ? cause_q : '0;

endmodule

`default_nettype wire

//--- logic/ptw_sv39.sv
`default_nettype none
`timescale 1ns/10ps

module ptw_sv39 #(
    parameter int unsigned PscidWidth = 20
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // Walk request
    input  logic                                 init_ptw_i,
    input  logic                                 is_store_i,
    input  logic [sv39_pkg::VaWidth-1:0]         req_iova_i,
    input  logic [PscidWidth-1:0]                pscid_i,
    input  logic [sv39_pkg::PpnWidth-1:0]        iosatp_ppn_i,
    // PTE read port
    output logic                                 ar_valid_o,
    output logic [sv39_pkg::PaWidth-1:0]         ar_addr_o,
    input  logic                                 ar_ready_i,
    input  logic                                 r_valid_i,
    input  logic [sv39_pkg::PteWidth-1:0]        r_data_i,
    input  logic [1:0]                           r_resp_i,
    output logic                                 r_ready_o,
    output logic                                 ptw_active_o,
    // IOTLB update
    output logic                                 update_o,
    output logic                                 up_1g_o,
    output logic                                 up_2m_o,
    output logic [sv39_pkg::VpnWidth-1:0]        up_vpn_o,
    output logic [PscidWidth-1:0]                up_pscid_o,
    output sv39_pkg::pte_t                       up_pte_o,
    // Fault report
    output logic                                 ptw_error_o,
    output logic [ptw_fault_pkg::CauseWidth-1:0] cause_code_o
);

    walk_req_if #(.PscidWidth(PscidWidth)) req_if ();
    walk_res_if #(.PscidWidth(PscidWidth)) res_if ();

    ptw_req_intake #(
        .PscidWidth (PscidWidth)
    ) i_intake (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .init_ptw_i (init_ptw_i),
        .busy_i     (ptw_active_o),
        .iova_i     (req_iova_i),
        .pscid_i    (pscid_i),
        .is_store_i (is_store_i),
        .root_ppn_i (iosatp_ppn_i),
        .req        (req_if.intake)
    );

    ptw_walker i_walker (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .req        (req_if.walker),
        .res        (res_if.walker),
        .busy_o     (ptw_active_o),
        .ar_valid_o (ar_valid_o),
        .ar_addr_o  (ar_addr_o),
        .ar_ready_i (ar_ready_i),
        .r_valid_i  (r_valid_i),
        .r_data_i   (r_data_i),
        .r_resp_i   (r_resp_i),
        .r_ready_o  (r_ready_o)
    );

    ptw_outcome_report #(
        .PscidWidth (PscidWidth)
    ) i_report (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .res          (res_if.report),
        .update_o     (update_o),
        .up_1g_o      (up_1g_o),
        .up_2m_o      (up_2m_o),
        .up_vpn_o     (up_vpn_o),
        .up_pscid_o   (up_pscid_o),
        .up_pte_o     (up_pte_o),
        .ptw_error_o  (ptw_error_o),
        .cause_code_o (cause_code_o)
    );

endmodule

`default_nettype wire

//--- dv/tb_ptw_ref.svh
`ifndef TB_PTW_REF_SVH
`define TB_PTW_REF_SVH

// What the report outputs should show for one walk
typedef struct packed {
    logic              is_err;
    logic              is_1g;
    logic              is_2m;
    logic [26:0]       vpn;
    logic [PscidW-1:0] pscid;
    logic [63:0]       pte;
    logic [11:0]       cause;
} exp_t;

// One xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Next value for the table builder and the stimulus
function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// Unwritten memory reads back a word built from its whole address
function automatic logic [63:0] fill_pte(input logic [55:0] addr);
    return {addr[7:0], addr};
endfunction

// Builds the tables for one walk in fresh pages
// Kind picks the leaf level and the planted fault
// 0 4K, 1 1G, 2 2M, 3 global pointer, 4 invalid, 5 reserved, 6 misaligned 2M,
// 7 store without d, 8 pointer with a/d/u, 9 pointer at LVL3, 10 bus error
task automatic build_walk(input int t, input int kind, output logic [38:0] iova,
                          output logic [43:0] root);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [43:0] leaf_ppn;
    logic [63:0] pte1, pte2, pte3;
    logic [55:0] a2;
    int          depth;
    r0 = next_rand();
    r1 = next_rand();
    iova = {r0[6:0], r1};
    leaf_ppn = {r1[11:0], r0 ^ r1};
    // Three pages per test, root then second and third level tables
    root = 44'h100 + 44'(3 * t);
    depth = (kind == 1) ? 1 : ((kind == 2 || kind == 6) ? 2 : 3);
    if (depth == 1) leaf_ppn[17:0] = '0;
    if (depth == 2) leaf_ppn[8:0] = '0;
    // Leaf has d, a, x, w, r, v
    pte3 = {10'b0, leaf_ppn, 10'h0cf};
    pte2 = (depth == 2) ? pte3 : {10'b0, root + 44'd2, 10'h001};
    pte1 = (depth == 1) ? pte3 : {10'b0, root + 44'd1, 10'h001};
    if (kind < 3 && r1[20]) pte1[5] = 1'b1;
    case (kind)
        3:       pte1[5] = 1'b1;
        4:       pte2[0] = 1'b0;
        5:       pte3[60] = 1'b1;
        6:       pte2[10] = 1'b1;
        7:       pte3[7] = 1'b0;
        8:       pte1 = pte1 | (64'h1 << (r0[0] ? 4 : (r0[1] ? 6 : 7)));
        9:       pte3 = {10'b0, leaf_ppn, 10'h001};
        // Contents do not matter once the read errors
        10:      pte2 = {r0, r1};
        default: ;
    endcase
    a2 = {root + 44'd1, iova[29:21], 3'b000};
    mem[{root, iova[38:30], 3'b000}] = pte1;
    if (depth > 1) mem[a2] = pte2;
    if (depth > 2) mem[{root + 44'd2, iova[20:12], 3'b000}] = pte3;
    if (kind == 10) bad_addr[a2] = 1'b1;
endtask

// Software walk over the same memory by the Sv39 rules
function automatic exp_t ref_walk(input logic [38:0] iova, input logic [43:0] root,
                                  input logic [PscidW-1:0] pscid, input logic st);
    exp_t        e;
    logic [43:0] ppn;
    logic [55:0] addr;
    logic [63:0] pte;
    logic        glob;
    logic        leaf;
    logic        bad;
    e = '0;
    ppn = root;
    glob = 1'b0;
    for (int lvl = 0; lvl < 3; lvl++) begin
        addr = {ppn, 9'(iova >> (30 - 9 * lvl)), 3'b000};
        // Error response wins over anything in the entry
        if (bad_addr.exists(addr)) begin
            e.is_err = 1'b1;
            e.cause = 12'd274;
            return e;
        end
        pte = mem.exists(addr) ? mem[addr] : fill_pte(addr);
        glob = glob | pte[5];
        leaf = pte[1] | pte[3];
        bad = !pte[0] || (pte[2] && !pte[1]) || (pte[63:54] != '0);
        if (leaf) begin
            bad = bad || !pte[1] || !pte[6] || (st && !pte[7]);
            // Superpage PPN aligned to 1G or 2M
            bad = bad || (lvl == 0 && pte[27:10] != '0) || (lvl == 1 && pte[18:10] != '0);
        end else begin
            bad = bad || pte[4] || pte[6] || pte[7] || lvl == 2;
        end
        if (bad) begin
            e.is_err = 1'b1;
            e.cause = st ? 12'd15 : 12'd13;
            return e;
        end
        if (leaf) begin
            e.is_1g = (lvl == 0);
            e.is_2m = (lvl == 1);
            e.vpn = iova[38:12];
            e.pscid = pscid;
            e.pte = pte | {58'b0, glob, 5'b0};
            return e;
        end
        ppn = pte[53:10];
    end
    return e;
endfunction

`endif

//--- dv/tb_ptw_sv39.sv
`default_nettype none
`timescale 1ns/10ps

module tb_ptw_sv39;
    import sv39_pkg::*;

    localparam int PscidW   = 20;
    localparam int NumTests = 40;
    // Three reads with up to ten cycles each, plus trigger, stall and drain time
    localparam int TimeoutCycles = NumTests * (3 * 10 + 50) + 100;

    logic                clk_i = 1'b0;
    logic                rst_ni;
    logic                init_ptw_i;
    logic                is_store_i;
    logic [VaWidth-1:0]  req_iova_i;
    logic [PscidW-1:0]   pscid_i;
    logic [PpnWidth-1:0] iosatp_ppn_i;
    logic                ar_valid_o;
    logic [PaWidth-1:0]  ar_addr_o;
    logic                ar_ready_i = 1'b0;
    logic                r_valid_i = 1'b0;
    logic [63:0]         r_data_i = '0;
    logic [1:0]          r_resp_i = 2'b00;
    logic                r_ready_o;
    logic                ptw_active_o;
    logic                update_o;
    logic                up_1g_o;
    logic                up_2m_o;
    logic [VpnWidth-1:0] up_vpn_o;
    logic [PscidW-1:0]   up_pscid_o;
    logic [63:0]         up_pte_o;
    logic                ptw_error_o;
    logic [11:0]         cause_code_o;

    // Sparse PTE memory and the addresses that answer with SLVERR
    logic [63:0]        mem [logic [PaWidth-1:0]];
    bit                 bad_addr [logic [PaWidth-1:0]];
    logic [31:0]        rng_state = 32'h82c1a944;
    // Stall generator of the memory model
    logic [31:0]        stall_rng = 32'h82c1a944;
    logic               hold_resp = 1'b0;
    logic               rd_pend = 1'b0;
    logic [PaWidth-1:0] rd_addr = '0;
    logic [1:0]         ar_cnt = 2'd0;
    logic [1:0]         r_cnt = 2'd0;
    int                 n_checks = 0;
    int                 n_errors = 0;
    int                 n_outcomes = 0;
    int                 n_walks = 0;

    `include "tb_ptw_ref.svh"

    exp_t exp_q[$];

    ptw_sv39 #(.PscidWidth(PscidW)) i_dut (.*);

    always #50 clk_i = ~clk_i;

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Memory model with ready and valid each 0 to 3 cycles late
    always @(posedge clk_i) begin : mem_model
        logic [31:0] rnd;
        stall_rng = xorshift32(stall_rng);
        rnd = stall_rng;
        if (!rst_ni) begin
            ar_ready_i <= 1'b0;
            r_valid_i  <= 1'b0;
            rd_pend    <= 1'b0;
        end else begin
            if (ar_valid_o && ar_ready_i) begin
                ar_ready_i <= 1'b0;
                rd_pend    <= 1'b1;
                rd_addr    <= ar_addr_o;
                r_cnt      <= rnd[1:0];
                ar_cnt     <= rnd[3:2];
            end else if (ar_valid_o && !rd_pend) begin
                if (ar_cnt == 2'd0) ar_ready_i <= 1'b1;
                else ar_cnt <= ar_cnt - 2'd1;
            end
            if (r_valid_i && r_ready_o) begin
                r_valid_i <= 1'b0;
                r_data_i  <= '0;
                r_resp_i  <= 2'b00;
            end else if (rd_pend && !r_valid_i && !hold_resp) begin
                if (r_cnt == 2'd0) begin
                    r_valid_i <= 1'b1;
                    r_data_i  <= mem.exists(rd_addr) ? mem[rd_addr] : fill_pte(rd_addr);
                    r_resp_i  <= bad_addr.exists(rd_addr) ? 2'b10 : 2'b00;
                    rd_pend   <= 1'b0;
                end else begin
                    r_cnt <= r_cnt - 2'd1;
                end
            end
        end
    end

    // Each report pulse is matched against the oldest started walk
    always @(negedge clk_i) begin : compare
        exp_t e;
        if (rst_ni && (update_o || ptw_error_o)) begin
            n_outcomes++;
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("Outcome at %0t ns arrived with no walk started", $time);
            end else begin
                e = exp_q.pop_front();
                check_val("update_o", 64'(update_o), 64'(!e.is_err));
                check_val("ptw_error_o", 64'(ptw_error_o), 64'(e.is_err));
                check_val("up_1g_o", 64'(up_1g_o), 64'(e.is_1g));
                check_val("up_2m_o", 64'(up_2m_o), 64'(e.is_2m));
                check_val("up_vpn_o", 64'(up_vpn_o), 64'(e.vpn));
                check_val("up_pscid_o", 64'(up_pscid_o), 64'(e.pscid));
                check_val("up_pte_o", up_pte_o, e.pte);
                check_val("cause_code_o", 64'(cause_code_o), 64'(e.cause));
            end
        end
    end

    // Two more edges while the stalled walk is busy
    // Neither may start a walk
    task automatic toggle_trigger_busy();
        repeat (3) @(posedge clk_i);
        for (int i = 0; i < 2; i++) begin
            init_ptw_i <= 1'b0;
            req_iova_i <= ~req_iova_i;
            @(posedge clk_i);
            init_ptw_i <= 1'b1;
            @(posedge clk_i);
        end
        @(negedge clk_i);
        check_val("ptw_active_o", 64'(ptw_active_o), 64'd1);
        @(posedge clk_i);
        hold_resp <= 1'b0;
    endtask

    initial begin : stimulus
        exp_t        e;
        logic [31:0] rnd;
        logic [38:0] iova;
        logic [43:0] root;
        int          kind;
        logic        st;
        rst_ni       <= 1'b0;
        init_ptw_i   <= 1'b0;
        is_store_i   <= 1'b0;
        req_iova_i   <= '0;
        pscid_i      <= '0;
        iosatp_ppn_i <= '0;
        repeat (8) @(posedge clk_i);
        check_val("outputs in reset",
                  64'({ar_valid_o, r_ready_o, update_o, ptw_error_o, ptw_active_o}), 64'd0);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);
        // Directed kinds first, then random kinds and access types
        for (int t = 0; t < NumTests; t++) begin
            rnd = next_rand();
            kind = (t < 11) ? t : int'(rnd % 32'd11);
            st = (kind == 7) ? 1'b1 : ((t < 11) ? t[0] : rnd[8]);
            build_walk(t, kind, iova, root);
            e = ref_walk(iova, root, rnd[31:12], st);
            exp_q.push_back(e);
            n_walks++;
            @(posedge clk_i);
            init_ptw_i   <= 1'b1;
            is_store_i   <= st;
            req_iova_i   <= iova;
            pscid_i      <= rnd[31:12];
            iosatp_ppn_i <= root;
            if (t % 5 == 3) begin
                hold_resp <= 1'b1;
                toggle_trigger_busy();
            end
            while (n_outcomes < n_walks) @(posedge clk_i);
            // Trigger stays high past the outcome without a second walk
            repeat (6) @(posedge clk_i);
            init_ptw_i <= 1'b0;
            @(posedge clk_i);
        end
        repeat (4) @(posedge clk_i);
        check_val("outcome count", 64'(n_outcomes), 64'(NumTests));
        $display("Checks: %0d, errors: %0d, outcomes: %0d", n_checks, n_errors, n_outcomes);
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TimeoutCycles * 100);
        $display("Timeout after %0d cycles with %0d of %0d walks reported, errors: %0d",
                 TimeoutCycles, n_outcomes, NumTests, n_errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+dv
common/sv39_pkg.sv
common/ptw_fault_pkg.sv
common/walk_req_if.sv
common/walk_res_if.sv
logic/ptw_req_intake.sv
walker/ptw_walker.sv
logic/ptw_outcome_report.sv
logic/ptw_sv39.sv
dv/tb_ptw_sv39.sv

//--- Bender.yml
package:
  name: ptw_sv39

sources:
  - common/sv39_pkg.sv
  - common/ptw_fault_pkg.sv
  - common/walk_req_if.sv
  - common/walk_res_if.sv
  - logic/ptw_req_intake.sv
  - walker/ptw_walker.sv
  - logic/ptw_outcome_report.sv
  - logic/ptw_sv39.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_ptw_sv39.sv
